//--- verilog/icache_cfg_pkg.sv
// fixed geometry of 2 ways x 32 sets x 16-byte lines; no translation, fetch address is physical
package icache_cfg_pkg;

  // ====================================================================
  // geometry
  // ====================================================================
  localparam int ADDR_W   = 32;
  localparam int LINE_B   = 16;              // bytes per line
  localparam int LINE_W   = LINE_B * 8;
  localparam int WAYS     = 2;
  localparam int SETS     = 32;
  localparam int OFFSET_W = $clog2(LINE_B);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // ====================================================================
  // vector types
  // ====================================================================
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [LINE_B-1:0]  be_t;      // one bit per line byte
  typedef logic [WAYS-1:0]    way_oh_t;  // one-hot way select

endpackage

//--- verilog/l2_bus_pkg.sv
// L2 read port only; tag is the icache source bit above a 3-bit refill sequence number
package l2_bus_pkg;

  localparam int   L2_TAG_W  = 4;
  localparam logic L2_SRC_IC = 1'b1;   // top tag bit marks icache traffic
  localparam int   L2_SEQ_W  = 3;

  typedef logic [L2_TAG_W-1:0] l2_tag_t;
  typedef logic [L2_SEQ_W-1:0] l2_seq_t;

endpackage

//--- verilog/ic_tag_array.sv
`timescale 1ns/1ps
// one way of tags; read returns one cycle after the index, a same-set write is not bypassed
module ic_tag_array (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  icache_cfg_pkg::index_t i_rd_index,
  input  logic                   i_wr,
  input  icache_cfg_pkg::index_t i_wr_index,
  input  icache_cfg_pkg::tag_t   i_wr_tag,
  output icache_cfg_pkg::tag_t   o_tag,
  output logic                   o_valid
);

  icache_cfg_pkg::tag_t            mem [icache_cfg_pkg::SETS];
  logic [icache_cfg_pkg::SETS-1:0] r_valid;   // one bit per set

  // tag storage
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem[i_wr_index] <= i_wr_tag;
    end
    o_tag <= mem[i_rd_index];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      o_valid <= 1'b0;
    end else begin
      if (i_wr) begin
        r_valid[i_wr_index] <= 1'b1;
      end
      o_valid <= r_valid[i_rd_index];
    end
  end

endmodule

//--- verilog/ic_data_array.sv
`timescale 1ns/1ps
// one way of line data; full-line writes only, contents undefined until the tag side marks valid
module ic_data_array (
  input  logic                   i_clk,
  input  icache_cfg_pkg::index_t i_rd_index,
  input  logic                   i_wr,
  input  icache_cfg_pkg::index_t i_wr_index,
  input  icache_cfg_pkg::line_t  i_wr_data,
  output icache_cfg_pkg::line_t  o_data
);

  icache_cfg_pkg::line_t mem [icache_cfg_pkg::SETS];

  // write port
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      mem[i_wr_index] <= i_wr_data;
    end
  end

  // registered read, one cycle
  always_ff @(posedge i_clk) begin
    o_data <= mem[i_rd_index];
  end

endmodule

//--- verilog/ic_lookup_pipe.sv
`timescale 1ns/1ps
// s0 accept, s1 tag compare, s2 data/miss; hits and misses only count while the refill side is idle
module ic_lookup_pipe (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_req_valid,
  input  icache_cfg_pkg::addr_t   i_req_addr,
  input  logic                    i_flush,
  input  logic                    i_idle,
  output logic                    o_resp_valid,
  output logic [icache_cfg_pkg::ADDR_W-icache_cfg_pkg::OFFSET_W-1:0] o_resp_line_addr,
  output icache_cfg_pkg::line_t   o_resp_data,
  output icache_cfg_pkg::be_t     o_resp_be,
  output logic                    o_miss,
  output icache_cfg_pkg::addr_t   o_miss_addr,
  output logic                    o_miss_start,
  output icache_cfg_pkg::addr_t   o_miss_addr_s1,
  input  logic                    i_fill_we,
  input  icache_cfg_pkg::way_oh_t i_fill_way,
  input  icache_cfg_pkg::index_t  i_fill_index,
  input  icache_cfg_pkg::tag_t    i_fill_tag,
  input  icache_cfg_pkg::line_t   i_fill_data
);

  localparam int ADDR_W   = icache_cfg_pkg::ADDR_W;
  localparam int OFFSET_W = icache_cfg_pkg::OFFSET_W;
  localparam int INDEX_W  = icache_cfg_pkg::INDEX_W;
  localparam int TAG_W    = icache_cfg_pkg::TAG_W;

  icache_cfg_pkg::index_t  w_s0_index;
  icache_cfg_pkg::index_t  w_s1_index;
  icache_cfg_pkg::tag_t    w_s1_req_tag;
  icache_cfg_pkg::tag_t    w_s1_tag [icache_cfg_pkg::WAYS];
  icache_cfg_pkg::way_oh_t w_s1_tag_valid;
  icache_cfg_pkg::way_oh_t w_s1_hit;
  icache_cfg_pkg::line_t   w_s2_data [icache_cfg_pkg::WAYS];

  logic                    r_s1_valid;
  icache_cfg_pkg::addr_t   r_s1_addr;
  logic                    r_s2_valid;
  icache_cfg_pkg::way_oh_t r_s2_hit_oh;
  icache_cfg_pkg::addr_t   r_s2_addr;

  assign w_s0_index   = i_req_addr[OFFSET_W +: INDEX_W];
  assign w_s1_index   = r_s1_addr[OFFSET_W +: INDEX_W];
  assign w_s1_req_tag = r_s1_addr[ADDR_W-1 -: TAG_W];

  // ====================================================================
  // per-way arrays
  // ====================================================================
  for (genvar g = 0; g < icache_cfg_pkg::WAYS; g++) begin : g_way
    ic_tag_array u_tag (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_rd_index (w_s0_index),
      .i_wr       (i_fill_we & i_fill_way[g]),   // only the victim way
      .i_wr_index (i_fill_index),
      .i_wr_tag   (i_fill_tag),
      .o_tag      (w_s1_tag[g]),
      .o_valid    (w_s1_tag_valid[g])
    );

    ic_data_array u_data (
      .i_clk      (i_clk),
      .i_rd_index (w_s1_index),
      .i_wr       (i_fill_we & i_fill_way[g]),
      .i_wr_index (i_fill_index),
      .i_wr_data  (i_fill_data),
      .o_data     (w_s2_data[g])
    );

    assign w_s1_hit[g] = w_s1_tag_valid[g] & (w_s1_tag[g] == w_s1_req_tag);
  end

  // ====================================================================
  // s1 / s2 registers
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid  <= 1'b0;
      r_s2_valid  <= 1'b0;
      r_s2_hit_oh <= '0;
      o_miss      <= 1'b0;
    end else begin
      r_s1_valid  <= i_req_valid & i_idle;   // ready is the idle state
      r_s2_valid  <= r_s1_valid & ~i_flush;
      r_s2_hit_oh <= w_s1_hit;
      o_miss      <= o_miss_start;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_addr <= i_req_addr;
    r_s2_addr <= r_s1_addr;
  end

  // miss decided at s1, shown at s2
  assign o_miss_start   = r_s1_valid & ~(|w_s1_hit) & i_idle & ~i_flush;
  assign o_miss_addr_s1 = r_s1_addr;
  assign o_miss_addr    = r_s2_addr;

  // way select
  always_comb begin
    o_resp_data = '0;
    for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
      if (r_s2_hit_oh[w]) begin
        o_resp_data = o_resp_data | w_s2_data[w];
      end
    end
  end

  assign o_resp_valid     = r_s2_valid & (|r_s2_hit_oh) & i_idle & ~i_flush;
  assign o_resp_line_addr = r_s2_addr[ADDR_W-1:OFFSET_W];
  assign o_resp_be        = {icache_cfg_pkg::LINE_B{1'b1}} << r_s2_addr[OFFSET_W-1:0];  // k..15

endmodule

//--- verilog/ic_refill_ctrl.sv
`timescale 1ns/1ps
// one outstanding L2 read; response always accepted, victim picked round robin, no replay of the miss
module ic_refill_ctrl (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_miss_start,
  input  icache_cfg_pkg::addr_t   i_miss_addr,
  output logic                    o_idle,
  output logic                    o_l2_req_valid,
  input  logic                    i_l2_req_ready,
  output icache_cfg_pkg::addr_t   o_l2_req_addr,
  output l2_bus_pkg::l2_tag_t     o_l2_req_tag,
  input  logic                    i_l2_resp_valid,
  input  l2_bus_pkg::l2_tag_t     i_l2_resp_tag,
  input  icache_cfg_pkg::line_t   i_l2_resp_data,
  output logic                    o_fill_we,
  output icache_cfg_pkg::way_oh_t o_fill_way,
  output icache_cfg_pkg::index_t  o_fill_index,
  output icache_cfg_pkg::tag_t    o_fill_tag,
  output icache_cfg_pkg::line_t   o_fill_data
);

  localparam int WAYS     = icache_cfg_pkg::WAYS;
  localparam int OFFSET_W = icache_cfg_pkg::OFFSET_W;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

  state_t                  r_state;
  icache_cfg_pkg::addr_t   r_line_addr;   // line aligned
  l2_bus_pkg::l2_seq_t     r_seq;
  icache_cfg_pkg::way_oh_t r_victim;
  logic                    w_resp_fire;

  assign o_l2_req_tag = {l2_bus_pkg::L2_SRC_IC, r_seq};
  assign w_resp_fire  = (r_state == ST_WAIT) & i_l2_resp_valid & (i_l2_resp_tag == o_l2_req_tag);

  // ====================================================================
  // miss state machine
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= ST_IDLE;
      r_seq    <= '0;
      r_victim <= WAYS'(1);   // way 0 first
    end else begin
      case (r_state)
        ST_IDLE: if (i_miss_start) r_state <= ST_REQ;
        ST_REQ:  if (i_l2_req_ready) r_state <= ST_WAIT;
        ST_WAIT: begin
          if (w_resp_fire) begin
            r_state  <= ST_IDLE;
            r_seq    <= r_seq + 1'b1;
            r_victim <= {r_victim[WAYS-2:0], r_victim[WAYS-1]};
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == ST_IDLE) && i_miss_start) begin
      r_line_addr <= {i_miss_addr[icache_cfg_pkg::ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  assign o_idle         = (r_state == ST_IDLE);
  assign o_l2_req_valid = (r_state == ST_REQ);
  assign o_l2_req_addr  = r_line_addr;

  // fill port
  assign o_fill_we    = w_resp_fire;
  assign o_fill_way   = r_victim;
  assign o_fill_index = r_line_addr[OFFSET_W +: icache_cfg_pkg::INDEX_W];
  assign o_fill_tag   = r_line_addr[icache_cfg_pkg::ADDR_W-1 -: icache_cfg_pkg::TAG_W];
  assign o_fill_data  = i_l2_resp_data;

endmodule

//--- verilog/ic_top.sv
`timescale 1ns/1ps
// icache top; fetches are refused while a refill runs, the requester must fetch again after a miss
module ic_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_req_valid,
  input  icache_cfg_pkg::addr_t i_req_addr,
  output logic                  o_req_ready,
  input  logic                  i_flush,
  output logic                  o_resp_valid,
  output logic [icache_cfg_pkg::ADDR_W-icache_cfg_pkg::OFFSET_W-1:0] o_resp_line_addr,
  output icache_cfg_pkg::line_t o_resp_data,
  output icache_cfg_pkg::be_t   o_resp_be,
  output logic                  o_miss,
  output icache_cfg_pkg::addr_t o_miss_addr,
  output logic                  o_l2_req_valid,
  input  logic                  i_l2_req_ready,
  output icache_cfg_pkg::addr_t o_l2_req_addr,
  output l2_bus_pkg::l2_tag_t   o_l2_req_tag,
  input  logic                  i_l2_resp_valid,
  input  l2_bus_pkg::l2_tag_t   i_l2_resp_tag,
  input  icache_cfg_pkg::line_t i_l2_resp_data
);

  logic                    w_idle;
  logic                    w_miss_start;
  icache_cfg_pkg::addr_t   w_miss_addr_s1;
  logic                    w_fill_we;
  icache_cfg_pkg::way_oh_t w_fill_way;
  icache_cfg_pkg::index_t  w_fill_index;
  icache_cfg_pkg::tag_t    w_fill_tag;
  icache_cfg_pkg::line_t   w_fill_data;

  assign o_req_ready = w_idle;

  ic_lookup_pipe u_lookup (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_req_valid      (i_req_valid),
    .i_req_addr       (i_req_addr),
    .i_flush          (i_flush),
    .i_idle           (w_idle),
    .o_resp_valid     (o_resp_valid),
    .o_resp_line_addr (o_resp_line_addr),
    .o_resp_data      (o_resp_data),
    .o_resp_be        (o_resp_be),
    .o_miss           (o_miss),
    .o_miss_addr      (o_miss_addr),
    .o_miss_start     (w_miss_start),
    .o_miss_addr_s1   (w_miss_addr_s1),
    .i_fill_we        (w_fill_we),
    .i_fill_way       (w_fill_way),
    .i_fill_index     (w_fill_index),
    .i_fill_tag       (w_fill_tag),
    .i_fill_data      (w_fill_data)
  );

  ic_refill_ctrl u_refill (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_miss_start    (w_miss_start),
    .i_miss_addr     (w_miss_addr_s1),
    .o_idle          (w_idle),
    .o_l2_req_valid  (o_l2_req_valid),
    .i_l2_req_ready  (i_l2_req_ready),
    .o_l2_req_addr   (o_l2_req_addr),
    .o_l2_req_tag    (o_l2_req_tag),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_tag   (i_l2_resp_tag),
    .i_l2_resp_data  (i_l2_resp_data),
    .o_fill_we       (w_fill_we),
    .o_fill_way      (w_fill_way),
    .o_fill_index    (w_fill_index),
    .o_fill_tag      (w_fill_tag),
    .o_fill_data     (w_fill_data)
  );

endmodule

//--- tests/ic_top_asserts.sv
`timescale 1ns/1ps
// protocol checks on the ic_top ports only; failures are also counted in fail_count
module ic_top_asserts (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_req_ready,
  input logic                  i_resp_valid,
  input logic                  i_miss,
  input logic                  i_l2_req_valid,
  input logic                  i_l2_req_ready,
  input icache_cfg_pkg::addr_t i_l2_req_addr,
  input l2_bus_pkg::l2_tag_t   i_l2_req_tag
);

  int unsigned fail_count = 0;

  // L2 request is held until accepted
  a_l2_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_l2_req_valid && !i_l2_req_ready |=>
      i_l2_req_valid && $stable(i_l2_req_addr) && $stable(i_l2_req_tag))
    else begin
      $error("L2 request dropped or changed before ready");
      fail_count++;
    end

  a_resp_or_miss: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      !(i_resp_valid && i_miss))
    else begin
      $error("response and miss high in the same cycle");
      fail_count++;
    end

  a_refused: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_l2_req_valid |-> !i_req_ready)
    else begin
      $error("fetch ready while an L2 request is pending");
      fail_count++;
    end

endmodule

bind ic_top ic_top_asserts u_asserts (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_req_ready    (o_req_ready),
  .i_resp_valid   (o_resp_valid),
  .i_miss         (o_miss),
  .i_l2_req_valid (o_l2_req_valid),
  .i_l2_req_ready (i_l2_req_ready),
  .i_l2_req_addr  (o_l2_req_addr),
  .i_l2_req_tag   (o_l2_req_tag)
);

//--- tests/tb_ic_top.sv
`timescale 1ns/1ps
// directed tests with an inline L2 model serving one request at a time; lines A, B, C share a set
module tb_ic_top;

  localparam icache_cfg_pkg::addr_t LINE_A = 32'h0000_1230;
  localparam icache_cfg_pkg::addr_t LINE_B = 32'h0000_1430;   // same index as A
  localparam icache_cfg_pkg::addr_t LINE_C = 32'h0000_1630;
  localparam icache_cfg_pkg::addr_t LINE_D = 32'h0004_5670;
  localparam icache_cfg_pkg::addr_t LINE_E = 32'h0008_9ab0;
  localparam icache_cfg_pkg::addr_t LINE_G = 32'h000c_def0;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_req_valid;
  icache_cfg_pkg::addr_t i_req_addr;
  logic                  o_req_ready;
  logic                  i_flush;
  logic                  o_resp_valid;
  logic [27:0]           o_resp_line_addr;
  icache_cfg_pkg::line_t o_resp_data;
  icache_cfg_pkg::be_t   o_resp_be;
  logic                  o_miss;
  icache_cfg_pkg::addr_t o_miss_addr;
  logic                  o_l2_req_valid;
  logic                  i_l2_req_ready;
  icache_cfg_pkg::addr_t o_l2_req_addr;
  l2_bus_pkg::l2_tag_t   o_l2_req_tag;
  logic                  i_l2_resp_valid;
  l2_bus_pkg::l2_tag_t   i_l2_resp_tag;
  icache_cfg_pkg::line_t i_l2_resp_data;

  int                  errors = 0;
  int                  timeouts = 0;
  logic [31:0]         lfsr = 32'h9e990e99;
  l2_bus_pkg::l2_seq_t exp_seq = '0;   // sequence of the next refill

  ic_top dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic int take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return int'(r);
  endfunction

  // each 32-bit word is its byte address ^ 5a5a0000
  function automatic icache_cfg_pkg::line_t line_pattern(input icache_cfg_pkg::addr_t a);
    icache_cfg_pkg::line_t d;
    for (int w = 0; w < 4; w++) begin
      d[32*w +: 32] = ({a[31:4], 4'h0} + 32'(4 * w)) ^ 32'h5a5a0000;
    end
    return d;
  endfunction

  function automatic icache_cfg_pkg::be_t expected_be(input int k);
    icache_cfg_pkg::be_t be;
    for (int b = 0; b < 16; b++) begin
      be[b] = (b >= k);
    end
    return be;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("FAIL t=%0t %s", $time, msg);
  endtask

  task automatic next_drive;
    @(posedge i_clk);
    #1;
  endtask

  task automatic settle;
    @(negedge i_clk);
  endtask

  // accept in N, outcome sampled in N+2
  task automatic fetch(input icache_cfg_pkg::addr_t a, input bit exp_hit,
                       input bit flush_s1, input bit flush_s2);
    next_drive;
    i_req_valid = 1'b1;
    i_req_addr  = a;
    settle;
    assert (o_req_ready) else report_mismatch($sformatf("fetch %h refused while idle", a));
    next_drive;
    i_req_valid = 1'b0;
    i_flush     = flush_s1;
    settle;
    next_drive;
    i_flush = flush_s2;
    settle;
    if (flush_s1 || flush_s2) begin
      assert (!o_resp_valid && !o_miss)
        else report_mismatch($sformatf("flushed fetch %h gave an output", a));
    end else if (exp_hit) begin
      assert (o_resp_valid && !o_miss) else report_mismatch($sformatf("no hit for %h", a));
      assert (o_resp_data == line_pattern(a))
        else report_mismatch($sformatf("data %h for %h", o_resp_data, a));
      assert (o_resp_line_addr == a[31:4])
        else report_mismatch($sformatf("line addr %h for %h", o_resp_line_addr, a));
      assert (o_resp_be == expected_be(int'(a[3:0])))
        else report_mismatch($sformatf("byte enables %h for %h", o_resp_be, a));
    end else begin
      assert (o_miss && !o_resp_valid && o_miss_addr == a)
        else report_mismatch($sformatf("no miss for %h (miss addr %h)", a, o_miss_addr));
    end
    next_drive;
    i_flush = 1'b0;
    settle;
  endtask

  // L2 model: stalls ready, optionally sends a wrong tag, then returns the line
  task automatic serve_l2(input icache_cfg_pkg::addr_t a, input int ready_delay,
                          input bit hold_fetch, input bit bad_tag);
    int                  n;
    int                  resp_delay;
    l2_bus_pkg::l2_tag_t req_tag;
    n = 0;
    while (!o_l2_req_valid && n < 20) begin
      next_drive;
      settle;
      n++;
    end
    if (!o_l2_req_valid) begin
      timeouts++;
      $display("timeout: no L2 request for line %h", a);
      return;
    end
    req_tag = o_l2_req_tag;
    assert (o_l2_req_addr == {a[31:4], 4'h0} && req_tag == {l2_bus_pkg::L2_SRC_IC, exp_seq})
      else report_mismatch($sformatf("L2 request %h tag %h", o_l2_req_addr, req_tag));
    for (int i = 0; i < ready_delay; i++) begin
      next_drive;
      i_req_valid = hold_fetch;
      i_req_addr  = LINE_A;
      settle;
      assert (!o_req_ready && !o_resp_valid && !o_miss && o_l2_req_tag == req_tag
              && o_l2_req_addr == {a[31:4], 4'h0})
        else report_mismatch("fetch side active or request moved under back-pressure");
    end
    next_drive;
    i_req_valid    = 1'b0;
    i_l2_req_ready = 1'b1;
    settle;
    next_drive;
    i_l2_req_ready = 1'b0;
    settle;
    resp_delay = take_bits(2);
    for (int i = 0; i < resp_delay; i++) begin
      next_drive;
      settle;
      assert (!o_req_ready) else report_mismatch("fetch ready before the fill");
    end
    if (bad_tag) begin
      next_drive;
      i_l2_resp_valid = 1'b1;
      i_l2_resp_tag   = req_tag ^ 4'b0001;
      i_l2_resp_data  = ~line_pattern(a);
      settle;
      next_drive;
      i_l2_resp_valid = 1'b0;
      settle;
      assert (!o_req_ready) else report_mismatch("wrong-tag response ended the refill");
    end
    next_drive;
    i_l2_resp_valid = 1'b1;
    i_l2_resp_tag   = req_tag;
    i_l2_resp_data  = line_pattern(a);
    settle;
    next_drive;
    i_l2_resp_valid = 1'b0;
    settle;
    assert (o_req_ready) else report_mismatch($sformatf("not idle after fill of %h", a));
    exp_seq = exp_seq + 1'b1;
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic reset_and_cold_miss;
    assert (o_req_ready && !o_resp_valid && !o_miss && !o_l2_req_valid)
      else report_mismatch("outputs not idle after reset");
    fetch(LINE_A, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_A, take_bits(2), 1'b0, 1'b0);   // way 0
  endtask

  task automatic hit_after_refill;
    fetch(LINE_A + 32'd5, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic round_robin_replacement;
    fetch(LINE_B, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_B, take_bits(2), 1'b0, 1'b0);   // way 1
    fetch(LINE_C, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_C, take_bits(2), 1'b0, 1'b0);   // evicts A
    fetch(LINE_B, 1'b1, 1'b0, 1'b0);
    fetch(LINE_C + 32'd12, 1'b1, 1'b0, 1'b0);
    fetch(LINE_A, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_A, take_bits(2), 1'b0, 1'b0);
  endtask

  task automatic l2_back_pressure;
    fetch(LINE_D, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_D, 3 + take_bits(4), 1'b1, 1'b0);
    fetch(LINE_D + 32'd2, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic response_tag_filter;
    fetch(LINE_E, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_E, take_bits(2), 1'b0, 1'b1);
    fetch(LINE_E + 32'd8, 1'b1, 1'b0, 1'b0);      // wrong-tag data not written
  endtask

  task automatic flush_in_flight;
    fetch(LINE_E, 1'b1, 1'b0, 1'b1);
    fetch(LINE_G, 1'b0, 1'b1, 1'b0);
    repeat (4) begin
      next_drive;
      settle;
      assert (!o_l2_req_valid && o_req_ready && !o_miss)
        else report_mismatch("flushed miss started a refill");
    end
    fetch(LINE_G, 1'b0, 1'b0, 1'b0);
    serve_l2(LINE_G, take_bits(2), 1'b0, 1'b0);
    fetch(LINE_G + 32'd15, 1'b1, 1'b0, 1'b0);
  endtask

  initial begin
    int unsigned assert_fails;
    i_reset_n       = 1'b0;
    i_req_valid     = 1'b0;
    i_req_addr      = '0;
    i_flush         = 1'b0;
    i_l2_req_ready  = 1'b0;
    i_l2_resp_valid = 1'b0;
    i_l2_resp_tag   = '0;
    i_l2_resp_data  = '0;
    repeat (16) @(posedge i_clk);
    #1 i_reset_n = 1'b1;
    settle;
    reset_and_cold_miss;
    hit_after_refill;
    round_robin_replacement;
    l2_back_pressure;
    response_tag_filter;
    flush_in_flight;
    assert_fails = dut0.u_asserts.fail_count;
    $display("errors=%0d timeouts=%0d assertion_failures=%0d", errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- icache_sub.f
verilog/icache_cfg_pkg.sv
verilog/l2_bus_pkg.sv
verilog/ic_tag_array.sv
verilog/ic_data_array.sv
verilog/ic_lookup_pipe.sv
verilog/ic_refill_ctrl.sv
verilog/ic_top.sv
tests/ic_top_asserts.sv
tests/tb_ic_top.sv

//--- Makefile
TOP := tb_ic_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f icache_sub.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f icache_sub.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
